// File: rx_iq_pkg.sv
// rx iq rate adapter definitions
`default_nettype none

package rx_iq_pkg;

    // width of one i or q component
    localparam int iq_width = 16;

    // one dual-antenna sample
    // antenna 1 in the upper half, q above i on each antenna
    typedef struct packed {
        logic [iq_width-1:0] q1;
        logic [iq_width-1:0] i1;
        logic [iq_width-1:0] q0;
        logic [iq_width-1:0] i0;
    } iq_sample_t;

    // fifo geometry
    localparam int fifo_depth = 32;
    // fill count spans 0 to fifo_depth inclusive
    localparam int fifo_count_w = 6;

    // fill-level bands for the read pacer
    // below fill_low the pacer stretches its period by one clock
    localparam int fill_low = 11;
    // at or above fill_high the period shrinks by one clock
    localparam int fill_high = 22;

endpackage

`default_nettype wire

// File: iq_sync_fifo.sv
// single clock fwft sample fifo
`default_nettype none
`timescale 1ns/1ps

module iq_sync_fifo (
    input  logic                               clk,
    input  logic                               rstn,
    // write side
    input  logic                               wr_en,
    input  rx_iq_pkg::iq_sample_t              wr_data,
    // read side with head valid whenever empty is low
    input  logic                               rd_en,
    output rx_iq_pkg::iq_sample_t              head,
    output logic                               empty,
    output logic                               full,
    output logic [rx_iq_pkg::fifo_count_w-1:0] count
);
    import rx_iq_pkg::*;

    // pointer width for the storage index
    localparam int ptr_w = $clog2(fifo_depth);
    localparam logic [ptr_w-1:0] last_idx = ptr_w'(fifo_depth - 1);
    localparam logic [fifo_count_w-1:0] count_full = fifo_count_w'(fifo_depth);

    // sample storage
    iq_sample_t mem [fifo_depth];

    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [fifo_count_w-1:0] occ;

    // qualified operations
    logic do_wr;
    logic do_rd;

    // drop writes once full
    assign do_wr = wr_en && !full;
    // read side trusts the pacer never to pop while empty
    assign do_rd = rd_en;

    // status straight from the occupancy counter
    assign empty = (occ == '0);
    assign full  = (occ == count_full);
    assign count = occ;

    // first word falls through with the entry at rd_ptr always on head
    assign head = mem[rd_ptr];

    // storage write
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // write pointer wraps after the last entry
    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr <= '0;
        end else if (do_wr) begin
            if (wr_ptr == last_idx) begin
                wr_ptr <= '0;
            end else begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

    // read pointer moves so the next word shows on head after the pop edge
    always_ff @(posedge clk) begin
        if (!rstn) begin
            rd_ptr <= '0;
        end else if (do_rd) begin
            if (rd_ptr == last_idx) begin
                rd_ptr <= '0;
            end else begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // occupancy updates on the same edge as the operation
    always_ff @(posedge clk) begin
        if (!rstn) begin
            occ <= '0;
        end else begin
            case ({do_wr, do_rd})
                2'b10: begin
                    occ <= occ + 1'b1;
                end
                2'b01: begin
                    occ <= occ - 1'b1;
                end
                // push and pop together or idle
                default: begin
                    occ <= occ;
                end
            endcase
        end
    end

    // the pacer never pops an empty fifo
    rd_while_empty: assert property (
        @(posedge clk) disable iff (!rstn)
        rd_en |-> !empty
    ) else $error("fifo read strobe while empty");

    // occupancy stays within the storage size
    count_in_range: assert property (
        @(posedge clk) disable iff (!rstn)
        occ <= count_full
    ) else $error("fifo count %0d above depth", occ);

    // overflow loses the sample
    wr_while_full: assert property (
        @(posedge clk) disable iff (!rstn)
        wr_en |-> !full
    ) else $warning("fifo write while full, sample dropped");

endmodule

`default_nettype wire

// File: rx_read_pacer.sv
// adaptive fifo read pacer
`default_nettype none
`timescale 1ns/1ps

module rx_read_pacer #(
    parameter int num_clk_per_sample = 5,
    parameter int sampling_rate_mhz  = 20,
    parameter int num_clk_per_us     = 100
) (
    input  logic                               clk,
    input  logic                               rstn,
    // fifo status and head word
    input  logic                               empty,
    input  logic [rx_iq_pkg::fifo_count_w-1:0] count,
    input  rx_iq_pkg::iq_sample_t              head,
    // receiver-side controls
    input  logic                               fifo_out_en,
    input  logic                               bb_20m_en,
    input  logic                               valid_delay_sel,
    // pop strobe back to the fifo
    output logic                               rd_en,
    // to the baseband receiver
    output rx_iq_pkg::iq_sample_t              sample_out,
    output logic                               sample_out_valid
);
    import rx_iq_pkg::*;

    // nominal counter top is one less than clocks per sample
    localparam int top_nom = num_clk_per_sample - 1;
    // counter must hold nominal plus one
    localparam int cnt_w = $clog2(num_clk_per_sample + 1);
    // clock is not an integer multiple of the sample rate
    localparam bit fractional = (num_clk_per_sample * sampling_rate_mhz) != num_clk_per_us;

    // the three period choices
    localparam logic [cnt_w-1:0] top_slow = cnt_w'(top_nom + 1);
    localparam logic [cnt_w-1:0] top_mid  = cnt_w'(top_nom);
    localparam logic [cnt_w-1:0] top_fast = cnt_w'(top_nom - 1);

    // fill thresholds at count width
    localparam logic [fifo_count_w-1:0] lo_thr = fifo_count_w'(fill_low);
    localparam logic [fifo_count_w-1:0] hi_thr = fifo_count_w'(fill_high);

    logic [cnt_w-1:0] counter;
    logic [cnt_w-1:0] top;
    logic [cnt_w-1:0] top_next;
    // flips every sample slot for the fractional dither
    logic             dither;
    logic             tick;

    // delayed output stage
    logic             valid_q;
    iq_sample_t       data_q;

    // one read slot per counter wrap
    assign tick = (counter == '0);

    // pop when paced or forced, data present and output gate open
    assign rd_en = (tick || bb_20m_en) && !empty && fifo_out_en;

    // next period from the fill level
    always_comb begin
        if (count < lo_thr) begin
            // running dry so read slower
            top_next = top_slow;
        end else if (count < hi_thr) begin
            // normal band
            if (fractional) begin
                top_next = dither ? top_mid : top_slow;
            end else begin
                top_next = top_mid;
            end
        end else begin
            // filling up so read faster
            // fractional mode only drops the stretch
            top_next = fractional ? top_mid : top_fast;
        end
    end

    // pacing counter counts 0 up to top then wraps
    always_ff @(posedge clk) begin
        if (!rstn) begin
            counter <= '0;
        end else if (counter == top) begin
            counter <= '0;
        end else begin
            counter <= counter + 1'b1;
        end
    end

    // top and dither update once per sample slot
    always_ff @(posedge clk) begin
        if (!rstn) begin
            top    <= top_mid;
            dither <= 1'b0;
        end else if (tick) begin
            top    <= top_next;
            dither <= ~dither;
        end
    end

    // valid one cycle after the read
    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= rd_en;
        end
    end

    // capture the popped word alongside its valid
    always_ff @(posedge clk) begin
        if (rd_en) begin
            data_q <= head;
        end
    end

    // high select takes the read cycle directly
    assign sample_out_valid = valid_delay_sel ? rd_en : valid_q;
    assign sample_out       = valid_delay_sel ? head : data_q;

    // counter stays under the running top and the top within one clock of nominal
    top_in_band: assert property (
        @(posedge clk) disable iff (!rstn)
        (counter <= top) && (top >= top_fast) && (top <= top_slow)
    ) else $error("pacer counter %0d past top %0d or top outside band", counter, top);

endmodule

`default_nettype wire

// File: rx_iq_intf.sv
// rx iq rate adapter top
`default_nettype none
`timescale 1ns/1ps

module rx_iq_intf #(
    parameter int num_clk_per_sample = 5,
    parameter int sampling_rate_mhz  = 20,
    parameter int num_clk_per_us     = 100
) (
    input  logic                  clk,
    input  logic                  rstn,
    // front-end samples already in the clk domain
    input  rx_iq_pkg::iq_sample_t sample_in,
    input  logic                  sample_in_valid,
    // write and read gates
    input  logic                  fifo_in_en,
    input  logic                  fifo_out_en,
    // drain one sample per clock
    input  logic                  bb_20m_en,
    input  logic                  valid_delay_sel,
    // to the baseband receiver
    output rx_iq_pkg::iq_sample_t sample_out,
    output logic                  sample_out_valid,
    output logic                  fifo_emptyn
);
    import rx_iq_pkg::*;

    // fifo to pacer
    iq_sample_t              fifo_head;
    logic                    fifo_empty;
    logic [fifo_count_w-1:0] fifo_count;
    // pacer to fifo
    logic                    fifo_rd;
    // gated write strobe
    logic                    fifo_wr;

    // input gate
    assign fifo_wr = sample_in_valid & fifo_in_en;

    // occupancy status for the receiver
    assign fifo_emptyn = ~fifo_empty;

    // sample buffer
    iq_sync_fifo u_fifo (
        .clk     (clk),
        .rstn    (rstn),
        .wr_en   (fifo_wr),
        .wr_data (sample_in),
        .rd_en   (fifo_rd),
        .head    (fifo_head),
        .empty   (fifo_empty),
        .full    (),
        .count   (fifo_count)
    );

    // rate control and output staging
    rx_read_pacer #(
        .num_clk_per_sample (num_clk_per_sample),
        .sampling_rate_mhz  (sampling_rate_mhz),
        .num_clk_per_us     (num_clk_per_us)
    ) u_pacer (
        .clk              (clk),
        .rstn             (rstn),
        .empty            (fifo_empty),
        .count            (fifo_count),
        .head             (fifo_head),
        .fifo_out_en      (fifo_out_en),
        .bb_20m_en        (bb_20m_en),
        .valid_delay_sel  (valid_delay_sel),
        .rd_en            (fifo_rd),
        .sample_out       (sample_out),
        .sample_out_valid (sample_out_valid)
    );

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
// testbench clock and reset
`default_nettype none
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int period_ns    = 10,
    parameter int reset_cycles = 8
) (
    output logic clk,
    output logic rstn
);
    // free running clock
    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    // reset held low for a fixed number of rising edges
    initial begin
        rstn = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rstn <= 1'b1;
    end

endmodule

`default_nettype wire

// File: rx_iq_checker.sv
// rx iq output checker
`default_nettype none
`timescale 1ns/1ps

module rx_iq_checker #(
    parameter int num_clk_per_sample = 5
) (
    input logic                  clk,
    input logic                  rstn,
    input rx_iq_pkg::iq_sample_t sample_in,
    input logic                  sample_in_valid,
    input logic                  fifo_in_en,
    input logic                  fifo_out_en,
    input logic                  bb_20m_en,
    input logic                  valid_delay_sel,
    input rx_iq_pkg::iq_sample_t sample_out,
    input logic                  sample_out_valid,
    input logic                  fifo_emptyn
);
    import rx_iq_pkg::*;

    // words accepted by the fifo, oldest first
    logic [63:0] ref_q [$];
    int error_count = 0;
    int pushed = 0;
    int popped = 0;
    int dropped = 0;
    // spacing between output valids
    int gap = 0;
    int exp_gap = 0;
    bit have_last = 0;
    bit gap_ok = 0;
    // read-cycle view for the delayed output
    logic out_en_q = 1'b0;
    logic bb_q = 1'b0;
    logic emptyn_q = 1'b0;
    logic sel_q = 1'b0;
    logic cond_q = 1'b0;
    int occ_q = 0;

    always @(posedge clk) begin : sample_check
        int occ_now;
        int rd_count;
        logic rd_out;
        logic rd_bb;
        logic rd_ne;
        logic cond;
        logic [63:0] exp_word;
        if (!rstn) begin
            ref_q.delete();
            have_last = 0;
            gap_ok = 0;
            out_en_q = 1'b0;
            bb_q = 1'b0;
            emptyn_q = 1'b0;
            sel_q = 1'b0;
            cond_q = 1'b0;
            occ_q = 0;
        end else begin
            // fifo occupancy before this edge
            // a delayed valid was already popped one edge earlier
            occ_now = ref_q.size();
            if (sample_out_valid && !valid_delay_sel) begin
                occ_now = occ_now - 1;
            end
            if (fifo_emptyn !== (occ_now != 0)) begin
                $display("MISMATCH at %0t: fifo_emptyn %b with %0d samples held",
                         $time, fifo_emptyn, occ_now);
                error_count++;
            end
            // write gate and full drop
            if (sample_in_valid && fifo_in_en) begin
                if (occ_now >= fifo_depth) begin
                    dropped++;
                end else begin
                    ref_q.push_back(sample_in);
                    pushed++;
                end
            end
            // conditions of the cycle that made the read
            rd_out = valid_delay_sel ? fifo_out_en : out_en_q;
            rd_bb  = valid_delay_sel ? bb_20m_en : bb_q;
            rd_ne  = valid_delay_sel ? fifo_emptyn : emptyn_q;
            if (sample_out_valid) begin
                if (!(rd_out && rd_ne)) begin
                    $display("error at %0t: output valid while gated or empty", $time);
                    error_count++;
                end
                if (ref_q.size() == 0) begin
                    $display("error at %0t: output valid with nothing written", $time);
                    error_count++;
                end else begin
                    exp_word = ref_q.pop_front();
                    popped++;
                    if (sample_out !== exp_word) begin
                        $display("MISMATCH at %0t: sample_out %h expected %h",
                                 $time, sample_out, exp_word);
                        error_count++;
                    end
                end
                // paced spacing only when nothing interfered
                if (have_last && gap_ok && gap != exp_gap) begin
                    $display("MISMATCH at %0t: read spacing %0d expected %0d",
                             $time, gap, exp_gap);
                    error_count++;
                end
                // fill at the read sets the next period
                rd_count = valid_delay_sel ? occ_now : occ_q;
                if (rd_count < fill_low) begin
                    exp_gap = num_clk_per_sample + 1;
                end else if (rd_count < fill_high) begin
                    exp_gap = num_clk_per_sample;
                end else begin
                    exp_gap = num_clk_per_sample - 1;
                end
                have_last = 1;
                gap = 0;
                gap_ok = valid_delay_sel ? 1'b1 : cond_q;
            end else if (rd_bb && rd_out && rd_ne) begin
                $display("MISMATCH at %0t: no valid during force drain", $time);
                error_count++;
            end
            gap++;
            cond = fifo_emptyn && fifo_out_en && !bb_20m_en && (valid_delay_sel == sel_q);
            gap_ok = gap_ok && cond;
            out_en_q = fifo_out_en;
            bb_q = bb_20m_en;
            emptyn_q = fifo_emptyn;
            sel_q = valid_delay_sel;
            cond_q = cond;
            occ_q = occ_now;
        end
    end

    // leftover samples and the closing count line
    task automatic final_check(input int stim_errors);
        if (ref_q.size() != 0) begin
            $display("error: %0d written samples never came out", ref_q.size());
            error_count++;
        end
        if (fifo_emptyn !== 1'b0) begin
            $display("error: fifo not empty at end of run");
            error_count++;
        end
        error_count += stim_errors;
        $display("checker: %0d written, %0d read, %0d dropped, %0d errors",
                 pushed, popped, dropped, error_count);
    endtask

endmodule

`default_nettype wire

// File: tb_rx_iq_intf.sv
// rx iq rate adapter testbench
`default_nettype none
`timescale 1ns/1ps

module tb_rx_iq_intf;
    import rx_iq_pkg::*;

    localparam int clk_per_sample = 5;
    localparam int rate_mhz       = 20;
    localparam int clk_per_us     = 100;
    // slack on top of the paced run length
    localparam int margin_cycles  = 500;

    logic       clk;
    logic       rstn;
    iq_sample_t sample_in;
    logic       sample_in_valid;
    logic       fifo_in_en;
    logic       fifo_out_en;
    logic       bb_20m_en;
    logic       valid_delay_sel;
    iq_sample_t sample_out;
    logic       sample_out_valid;
    logic       fifo_emptyn;

    integer seed;
    integer fd;
    int     stim_errors;
    int     limit_cycles;
    int     run_length;

    tb_clock_gen #(
        .period_ns    (10),
        .reset_cycles (8)
    ) u_clk (
        .clk  (clk),
        .rstn (rstn)
    );

    rx_iq_intf #(
        .num_clk_per_sample (clk_per_sample),
        .sampling_rate_mhz  (rate_mhz),
        .num_clk_per_us     (clk_per_us)
    ) u_dut (
        .clk              (clk),
        .rstn             (rstn),
        .sample_in        (sample_in),
        .sample_in_valid  (sample_in_valid),
        .fifo_in_en       (fifo_in_en),
        .fifo_out_en      (fifo_out_en),
        .bb_20m_en        (bb_20m_en),
        .valid_delay_sel  (valid_delay_sel),
        .sample_out       (sample_out),
        .sample_out_valid (sample_out_valid),
        .fifo_emptyn      (fifo_emptyn)
    );

    rx_iq_checker #(
        .num_clk_per_sample (clk_per_sample)
    ) u_checker (
        .clk              (clk),
        .rstn             (rstn),
        .sample_in        (sample_in),
        .sample_in_valid  (sample_in_valid),
        .fifo_in_en       (fifo_in_en),
        .fifo_out_en      (fifo_out_en),
        .bb_20m_en        (bb_20m_en),
        .valid_delay_sel  (valid_delay_sel),
        .sample_out       (sample_out),
        .sample_out_valid (sample_out_valid),
        .fifo_emptyn      (fifo_emptyn)
    );

    // walk the cases file, drive the DUT only when execute is set
    // total sums burst lengths and idle cycles
    task automatic run_cases(input bit execute, output int total);
        reg [8*16-1:0]  op;
        reg [8*256-1:0] rest;
        logic [63:0]    word;
        int a;
        int b;
        int rc;
        int k;
        total = 0;
        fd = $fopen("rx_iq_cases.txt", "r");
        if (fd == 0) begin
            total = -1;
        end else begin
            while ($fscanf(fd, "%s", op) == 1) begin
                a = 0;
                b = 0;
                if (op == "#") begin
                    rc = $fgets(rest, fd);
                end else if (op == "burst") begin
                    rc = $fscanf(fd, "%d %d", a, b);
                    total += a;
                    for (k = 0; k < a; k++) begin
                        // literal words follow in the file
                        if (b == 0) begin
                            rc = $fscanf(fd, "%h", word);
                        end else if (execute) begin
                            word = {$random(seed), $random(seed)};
                        end
                        if (execute) begin
                            sample_in       <= word;
                            sample_in_valid <= 1'b1;
                            @(posedge clk);
                        end
                    end
                    if (execute) begin
                        sample_in_valid <= 1'b0;
                    end
                end else if (op == "gate") begin
                    rc = $fscanf(fd, "%d %d", a, b);
                    if (execute) begin
                        fifo_in_en  <= a[0];
                        fifo_out_en <= b[0];
                    end
                end else if (op == "force") begin
                    rc = $fscanf(fd, "%d", a);
                    if (execute) begin
                        bb_20m_en <= a[0];
                    end
                end else if (op == "delay") begin
                    rc = $fscanf(fd, "%d", a);
                    if (execute) begin
                        valid_delay_sel <= a[0];
                    end
                end else if (op == "idle") begin
                    rc = $fscanf(fd, "%d", a);
                    total += a;
                    if (execute) begin
                        repeat (a) @(posedge clk);
                    end
                end else begin
                    rc = 0;
                end
                if (rc <= 0 && execute) begin
                    $display("error: bad or unknown line in cases file");
                    stim_errors++;
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin : stimulus
        sample_in       = '0;
        sample_in_valid = 1'b0;
        fifo_in_en      = 1'b1;
        fifo_out_en     = 1'b1;
        bb_20m_en       = 1'b0;
        valid_delay_sel = 1'b0;
        seed            = 32'h5c97;
        stim_errors     = 0;
        limit_cycles    = 0;
        // first pass only measures the run
        run_cases(1'b0, run_length);
        if (run_length < 0) begin
            $display("error: cannot open rx_iq_cases.txt");
            stim_errors++;
        end else begin
            limit_cycles = run_length * (clk_per_sample + 2) + margin_cycles;
            wait (rstn === 1'b1);
            @(posedge clk);
            run_cases(1'b1, run_length);
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        u_checker.final_check(stim_errors);
        if (u_checker.error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // watchdog armed once the run length is known
    initial begin : watchdog
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", limit_cycles);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
rx_iq_pkg.sv
iq_sync_fifo.sv
rx_read_pacer.sv
rx_iq_intf.sv
tb_clock_gen.sv
rx_iq_checker.sv
tb_rx_iq_intf.sv

// File: Bender.yml
package:
  name: rx_iq_intf

dependencies: {}

sources:
  - rx_iq_pkg.sv
  - iq_sync_fifo.sv
  - rx_read_pacer.sv
  - rx_iq_intf.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - rx_iq_checker.sv
      - tb_rx_iq_intf.sv

// File: rx_iq_cases.txt
# op and arguments, one operation per line
# burst <n> <random 1|0, 0 takes n hex words> | gate <in> <out> | force <f> | delay <d> | idle <n>
delay 1
burst 4 0
0123456789abcdef
fedcba9876543210
00010002fffefffd
7fff8000a5a55a5a
idle 40
burst 30 1
idle 220
delay 0
burst 30 1
idle 220
gate 1 0
burst 16 1
force 1
gate 1 1
idle 30
force 0
gate 0 1
burst 8 1
idle 10
gate 1 0
burst 10 1
idle 30
gate 1 1
idle 90
gate 1 0
burst 40 1
idle 10
gate 1 1
idle 260
